//--- id_defs.svh
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

// data path and pc width
`define XLEN 32

// fetched instruction word
`define INSTR_W 32

// architectural register index
`define REG_ADDR_W 5

// one-hot alu select
`define ALU_OP_W 12

// load/store byte enables
`define MEM_MASK_W 4

`endif

//--- isa_pkg.sv
`include "id_defs.svh"

package isa_pkg;

  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

  // major opcodes in bits 31:26
  typedef enum logic [5:0] {
    OP_GRP0      = 6'h00,
    OP_LU12I     = 6'h05,
    OP_PCADDU12I = 6'h07,
    OP_LDST      = 6'h0a,
    OP_JIRL      = 6'h13,
    OP_B         = 6'h14,
    OP_BL        = 6'h15,
    OP_BEQ       = 6'h16,
    OP_BNE       = 6'h17,
    OP_BLT       = 6'h18,
    OP_BGE       = 6'h19,
    OP_BLTU      = 6'h1a,
    OP_BGEU      = 6'h1b
  } op_31_26_t;

  typedef logic [3:0] op_25_22_t;
  typedef logic [1:0] op_21_20_t;
  typedef logic [4:0] op_19_15_t;

  typedef struct packed {
    op_31_26_t op_31_26;
    op_25_22_t op_25_22;
    op_21_20_t op_21_20;
    op_19_15_t op_19_15;
    reg_addr_t rk;
    reg_addr_t rj;
    reg_addr_t rd;
  } instr_fields_t;

  // bit 0 is alu_add, declared last
  typedef struct packed {
    logic alu_lui;
    logic alu_sra;
    logic alu_srl;
    logic alu_sll;
    logic alu_xor;
    logic alu_or;
    logic alu_nor;
    logic alu_and;
    logic alu_sltu;
    logic alu_slt;
    logic alu_sub;
    logic alu_add;
  } alu_bits_t;

  typedef union packed {
    alu_bits_t                op;
    logic [`ALU_OP_W-1:0]     vec;
  } alu_op_t;

endpackage

//--- issue_pkg.sv
`include "id_defs.svh"

package issue_pkg;

  import isa_pkg::*;

  typedef struct packed {
    logic [`XLEN-1:0]    pc;
    logic [`INSTR_W-1:0] instr;
    logic                pc_is_jump;
  } fetch_entry_t;

  // raddr2 is rd for stores and conditional branches
  typedef struct packed {
    reg_addr_t raddr1;
    reg_addr_t raddr2;
  } rf_req_t;

  typedef struct packed {
    logic [`XLEN-1:0] rj_value;
    logic [`XLEN-1:0] rkd_value;
  } rf_data_t;

  typedef struct packed {
    logic may_jump;
    logic use_rj_value;
    logic use_less;
    logic need_less;
    logic use_zero;
    logic need_zero;
  } branch_ctrl_t;

  typedef struct packed {
    logic use_mul;
    logic use_high;
    logic is_unsigned;
    logic use_div;
    logic use_mod;
  } muldiv_ctrl_t;

  typedef struct packed {
    logic [`XLEN-1:0]       pc;
    logic                   pc_is_jump;
    alu_op_t                alu_op;
    logic [`MEM_MASK_W-1:0] mem_mask;
    logic                   res_from_mem;
    logic                   mem_we;
    logic                   gr_we;
    reg_addr_t              dest;
    logic                   src1_is_pc;
    logic                   src2_is_imm;
    logic                   src2_is_4;
    logic [`XLEN-1:0]       imm;
    logic [`XLEN-1:0]       rj_value;
    logic [`XLEN-1:0]       rkd_value;
    branch_ctrl_t           branch;
    muldiv_ctrl_t           muldiv;
  } uop_t;

  // what the pair check needs from each slot
  typedef struct packed {
    reg_addr_t dest;
    logic      gr_we;
    logic      use_rj;
    logic      use_rkd;
    logic      is_ls;
    logic      is_mul;
    logic      is_div;
    logic      jmp_and_wr;
  } hazard_t;

endpackage

//--- instr_decoder.sv
`timescale 1ns/100ps
`include "id_defs.svh"

module instr_decoder
  import isa_pkg::*;
  import issue_pkg::*;
(
  input  fetch_entry_t fetch,
  input  rf_data_t     rf_data,
  output uop_t         uop,
  output rf_req_t      rf_req,
  output hazard_t      hazard
);

  instr_fields_t f;
  logic grp0;
  logic grp_3r;
  logic grp_div;
  logic grp_shi;
  logic inst_add, inst_sub, inst_slt, inst_sltu;
  logic inst_nor, inst_and, inst_or, inst_xor;
  logic inst_sll, inst_srl, inst_sra;
  logic inst_slli, inst_srli, inst_srai;
  logic inst_addi, inst_slti, inst_sltui, inst_andi, inst_ori, inst_xori;
  logic inst_lu12i, inst_pcaddu;
  logic inst_ld_b, inst_ld_h, inst_ld_w, inst_ld_bu, inst_ld_hu;
  logic inst_st_b, inst_st_h, inst_st_w;
  logic inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu;
  logic inst_b, inst_bl, inst_jirl;
  logic inst_mul, inst_mulh, inst_mulhu;
  logic inst_div, inst_mod, inst_divu, inst_modu;
  logic is_load;
  logic is_store;
  logic is_cbr;
  logic need_ui5, need_si12, need_ui12, need_si16, need_si20, need_si26;
  logic src1_is_pc;
  logic src2_is_imm;
  logic src2_is_4;
  logic gr_we;
  logic may_jump;
  logic [`XLEN-1:0] imm;
  logic [`MEM_MASK_W-1:0] mem_mask;
  reg_addr_t dest;

  assign f = instr_fields_t'(fetch.instr);

  assign grp0    = f.op_31_26 == OP_GRP0;
  assign grp_3r  = grp0 && f.op_25_22 == 4'h0 && f.op_21_20 == 2'h1;
  assign grp_div = grp0 && f.op_25_22 == 4'h0 && f.op_21_20 == 2'h2;
  assign grp_shi = grp0 && f.op_25_22 == 4'h1 && f.op_21_20 == 2'h0;

  // three-register ops
  assign inst_add   = grp_3r && f.op_19_15 == 5'h00;
  assign inst_sub   = grp_3r && f.op_19_15 == 5'h02;
  assign inst_slt   = grp_3r && f.op_19_15 == 5'h04;
  assign inst_sltu  = grp_3r && f.op_19_15 == 5'h05;
  assign inst_nor   = grp_3r && f.op_19_15 == 5'h08;
  assign inst_and   = grp_3r && f.op_19_15 == 5'h09;
  assign inst_or    = grp_3r && f.op_19_15 == 5'h0a;
  assign inst_xor   = grp_3r && f.op_19_15 == 5'h0b;
  assign inst_sll   = grp_3r && f.op_19_15 == 5'h0e;
  assign inst_srl   = grp_3r && f.op_19_15 == 5'h0f;
  assign inst_sra   = grp_3r && f.op_19_15 == 5'h10;
  assign inst_mul   = grp_3r && f.op_19_15 == 5'h18;
  assign inst_mulh  = grp_3r && f.op_19_15 == 5'h19;
  assign inst_mulhu = grp_3r && f.op_19_15 == 5'h1a;
  assign inst_div   = grp_div && f.op_19_15 == 5'h00;
  assign inst_mod   = grp_div && f.op_19_15 == 5'h01;
  assign inst_divu  = grp_div && f.op_19_15 == 5'h02;
  assign inst_modu  = grp_div && f.op_19_15 == 5'h03;
  assign inst_slli  = grp_shi && f.op_19_15 == 5'h01;
  assign inst_srli  = grp_shi && f.op_19_15 == 5'h09;
  assign inst_srai  = grp_shi && f.op_19_15 == 5'h11;

  // 12-bit immediate forms
  assign inst_slti  = grp0 && f.op_25_22 == 4'h8;
  assign inst_sltui = grp0 && f.op_25_22 == 4'h9;
  assign inst_addi  = grp0 && f.op_25_22 == 4'ha;
  assign inst_andi  = grp0 && f.op_25_22 == 4'hd;
  assign inst_ori   = grp0 && f.op_25_22 == 4'he;
  assign inst_xori  = grp0 && f.op_25_22 == 4'hf;

  assign inst_lu12i  = f.op_31_26 == OP_LU12I && !f.op_25_22[3];
  assign inst_pcaddu = f.op_31_26 == OP_PCADDU12I && !f.op_25_22[3];

  assign inst_ld_b  = f.op_31_26 == OP_LDST && f.op_25_22 == 4'h0;
  assign inst_ld_h  = f.op_31_26 == OP_LDST && f.op_25_22 == 4'h1;
  assign inst_ld_w  = f.op_31_26 == OP_LDST && f.op_25_22 == 4'h2;
  assign inst_st_b  = f.op_31_26 == OP_LDST && f.op_25_22 == 4'h4;
  assign inst_st_h  = f.op_31_26 == OP_LDST && f.op_25_22 == 4'h5;
  assign inst_st_w  = f.op_31_26 == OP_LDST && f.op_25_22 == 4'h6;
  assign inst_ld_bu = f.op_31_26 == OP_LDST && f.op_25_22 == 4'h8;
  assign inst_ld_hu = f.op_31_26 == OP_LDST && f.op_25_22 == 4'h9;

  assign inst_jirl = f.op_31_26 == OP_JIRL;
  assign inst_b    = f.op_31_26 == OP_B;
  assign inst_bl   = f.op_31_26 == OP_BL;
  assign inst_beq  = f.op_31_26 == OP_BEQ;
  assign inst_bne  = f.op_31_26 == OP_BNE;
  assign inst_blt  = f.op_31_26 == OP_BLT;
  assign inst_bge  = f.op_31_26 == OP_BGE;
  assign inst_bltu = f.op_31_26 == OP_BLTU;
  assign inst_bgeu = f.op_31_26 == OP_BGEU;

  assign is_load  = inst_ld_b | inst_ld_h | inst_ld_w | inst_ld_bu | inst_ld_hu;
  assign is_store = inst_st_b | inst_st_h | inst_st_w;
  assign is_cbr   = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;

  assign need_ui5  = inst_slli | inst_srli | inst_srai;
  assign need_si12 = inst_addi | inst_slti | inst_sltui | is_load | is_store;
  assign need_ui12 = inst_andi | inst_ori | inst_xori;
  assign need_si16 = inst_jirl | is_cbr;
  assign need_si20 = inst_lu12i | inst_pcaddu;
  assign need_si26 = inst_b | inst_bl;

  always_comb
  begin
    imm = '0;
    if (need_si20)
      imm = {fetch.instr[24:5], 12'b0};
    else if (need_ui5)
      imm = {27'b0, f.rk};
    else if (need_si26)
      imm = {{6{fetch.instr[9]}}, fetch.instr[9:0], fetch.instr[25:10]};
    else if (need_si16)
      imm = {{16{fetch.instr[25]}}, fetch.instr[25:10]};
    else if (need_ui12)
      imm = {20'b0, fetch.instr[21:10]};
    else if (need_si12)
      imm = {{20{fetch.instr[21]}}, fetch.instr[21:10]};
  end

  assign mem_mask = (inst_ld_w | inst_st_w) ? 4'hf :
                    (inst_ld_h | inst_ld_hu | inst_st_h) ? 4'h3 :
                    (inst_ld_b | inst_ld_bu | inst_st_b) ? 4'h1 : 4'h0;

  assign src1_is_pc  = inst_jirl | inst_bl | inst_pcaddu;
  assign src2_is_4   = inst_jirl | inst_bl;
  assign src2_is_imm = need_ui5 | need_si12 | need_ui12 | need_si20;
  assign may_jump    = is_cbr | inst_b | inst_bl | inst_jirl;

  // unknown encodings must not write
  assign gr_we = inst_add | inst_sub | inst_slt | inst_sltu | inst_nor | inst_and | inst_or
               | inst_xor | inst_sll | inst_srl | inst_sra | inst_mul | inst_mulh | inst_mulhu
               | inst_div | inst_mod | inst_divu | inst_modu | need_ui5 | need_ui12
               | inst_addi | inst_slti | inst_sltui | need_si20 | is_load | inst_jirl | inst_bl;
  assign dest  = inst_bl ? reg_addr_t'(1) : f.rd;

  assign rf_req.raddr1 = f.rj;
  assign rf_req.raddr2 = (is_store | is_cbr) ? f.rd : f.rk;

  always_comb
  begin
    uop.pc                 = fetch.pc;
    uop.pc_is_jump         = fetch.pc_is_jump;
    uop.alu_op.op.alu_add  = inst_add | inst_addi | is_load | is_store | inst_jirl
                           | inst_bl | inst_pcaddu;
    uop.alu_op.op.alu_sub  = inst_sub | inst_beq | inst_bne;
    uop.alu_op.op.alu_slt  = inst_slt | inst_slti | inst_blt | inst_bge;
    uop.alu_op.op.alu_sltu = inst_sltu | inst_sltui | inst_bltu | inst_bgeu;
    uop.alu_op.op.alu_and  = inst_and | inst_andi;
    uop.alu_op.op.alu_nor  = inst_nor;
    uop.alu_op.op.alu_or   = inst_or | inst_ori;
    uop.alu_op.op.alu_xor  = inst_xor | inst_xori;
    uop.alu_op.op.alu_sll  = inst_sll | inst_slli;
    uop.alu_op.op.alu_srl  = inst_srl | inst_srli;
    uop.alu_op.op.alu_sra  = inst_sra | inst_srai;
    uop.alu_op.op.alu_lui  = inst_lu12i;
    uop.mem_mask           = mem_mask;
    uop.res_from_mem       = is_load;
    uop.mem_we             = is_store;
    uop.gr_we              = gr_we;
    uop.dest               = dest;
    uop.src1_is_pc         = src1_is_pc;
    uop.src2_is_imm        = src2_is_imm;
    uop.src2_is_4          = src2_is_4;
    uop.imm                = imm;
    uop.rj_value           = rf_data.rj_value;
    uop.rkd_value          = rf_data.rkd_value;
    uop.branch.may_jump     = may_jump;
    uop.branch.use_rj_value = inst_jirl;
    uop.branch.use_less     = inst_blt | inst_bge | inst_bltu | inst_bgeu;
    uop.branch.need_less    = inst_blt | inst_bltu;
    uop.branch.use_zero     = inst_beq | inst_bne;
    uop.branch.need_zero    = inst_beq;
    uop.muldiv.use_mul     = inst_mul | inst_mulh | inst_mulhu;
    uop.muldiv.use_high    = inst_mulh | inst_mulhu;
    uop.muldiv.is_unsigned = inst_mulhu | inst_divu | inst_modu | inst_ld_bu | inst_ld_hu;
    uop.muldiv.use_div     = inst_div | inst_mod | inst_divu | inst_modu;
    uop.muldiv.use_mod     = inst_mod | inst_modu;
  end

  assign hazard.dest       = dest;
  assign hazard.gr_we      = gr_we;
  assign hazard.use_rj     = inst_jirl | ~src1_is_pc;
  // stores read rd through the second port
  assign hazard.use_rkd    = ~(src2_is_imm | src2_is_4) | is_store;
  assign hazard.is_ls      = |mem_mask;
  assign hazard.is_mul     = inst_mul | inst_mulh | inst_mulhu;
  assign hazard.is_div     = inst_div | inst_mod | inst_divu | inst_modu;
  assign hazard.jmp_and_wr = gr_we & may_jump;

endmodule

//--- pair_check.sv
`timescale 1ns/100ps

module pair_check
  import issue_pkg::*;
(
  input  hazard_t older,
  input  hazard_t younger,
  input  rf_req_t younger_req,
  output logic    pair_ok
);

  logic link_after_long;
  logic raw_rj;
  logic raw_rkd;
  logic raw;
  logic both_ls;
  logic both_mul;
  logic both_div;

  // bl/jirl cannot follow a multi-cycle unit op in the same bundle
  assign link_after_long = younger.jmp_and_wr & (older.is_ls | older.is_mul | older.is_div);

  // r0 never creates a dependency
  assign raw_rj  = younger.use_rj && older.dest == younger_req.raddr1;
  assign raw_rkd = younger.use_rkd && older.dest == younger_req.raddr2;
  assign raw     = older.gr_we && |older.dest && (raw_rj || raw_rkd);

  // one memory port, one multiplier, one divider
  assign both_ls  = older.is_ls & younger.is_ls;
  assign both_mul = older.is_mul & younger.is_mul;
  assign both_div = older.is_div & younger.is_div;

  assign pair_ok = ~(link_after_long | raw | both_ls | both_mul | both_div);

endmodule

//--- issue_regs.sv
`timescale 1ns/100ps

module issue_regs
  import issue_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  uop_t uop0_in,
  input  uop_t uop1_in,
  input  logic valid0_in,
  input  logic valid1_in,
  input  logic exe_ready,
  input  logic flush_all,
  input  logic flush_younger,
  input  logic slot1_done,
  output uop_t uop0,
  output uop_t uop1,
  output logic valid0,
  output logic valid1
);

  logic clear0;
  logic clear1;

  // older slot survives a younger flush unless slot 1 already retired
  assign clear0 = flush_all | (flush_younger & slot1_done);
  assign clear1 = flush_all | flush_younger;

  always_ff @(posedge clk)
  begin
    if (!rst_n || clear0)
      valid0 <= 1'b0;
    else if (exe_ready)
      valid0 <= valid0_in;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n || clear1)
      valid1 <= 1'b0;
    else if (exe_ready)
      valid1 <= valid1_in;
  end

  always_ff @(posedge clk)
  begin
    if (exe_ready)
    begin
      uop0 <= uop0_in;
      uop1 <= uop1_in;
    end
  end

endmodule

//--- decode_stage.sv
`timescale 1ns/100ps

module decode_stage
  import issue_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  fetch_entry_t fetch0,
  input  fetch_entry_t fetch1,
  input  logic         fetch0_valid,
  input  logic         fetch1_valid,
  output logic [1:0]   pop,
  output rf_req_t      rf_req0,
  output rf_req_t      rf_req1,
  input  rf_data_t     rf_data0,
  input  rf_data_t     rf_data1,
  output uop_t         exe_uop0,
  output uop_t         exe_uop1,
  output logic         exe_valid0,
  output logic         exe_valid1,
  input  logic         exe_ready,
  input  logic         flush_all,
  input  logic         flush_younger,
  input  logic         slot1_done
);

  uop_t    uop0;
  uop_t    uop1;
  hazard_t haz0;
  hazard_t haz1;
  logic    pair_ok;
  logic    valid1_next;

  instr_decoder dec0_i (
    .fetch   (fetch0),
    .rf_data (rf_data0),
    .uop     (uop0),
    .rf_req  (rf_req0),
    .hazard  (haz0)
  );

  instr_decoder dec1_i (
    .fetch   (fetch1),
    .rf_data (rf_data1),
    .uop     (uop1),
    .rf_req  (rf_req1),
    .hazard  (haz1)
  );

  pair_check pair_i (
    .older       (haz0),
    .younger     (haz1),
    .younger_req (rf_req1),
    .pair_ok     (pair_ok)
  );

  // younger goes out only when it can share the bundle
  assign valid1_next = fetch1_valid & pair_ok;
  assign pop         = {valid1_next & exe_ready, fetch0_valid & exe_ready};

  issue_regs regs_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .uop0_in       (uop0),
    .uop1_in       (uop1),
    .valid0_in     (fetch0_valid),
    .valid1_in     (valid1_next),
    .exe_ready     (exe_ready),
    .flush_all     (flush_all),
    .flush_younger (flush_younger),
    .slot1_done    (slot1_done),
    .uop0          (exe_uop0),
    .uop1          (exe_uop1),
    .valid0        (exe_valid0),
    .valid1        (exe_valid1)
  );

endmodule

//--- decode_props.sv
`timescale 1ns/100ps

module decode_props (
  input logic       clk,
  input logic       rst_n,
  input logic [1:0] pop,
  input logic       exe_ready,
  input logic       exe_valid0,
  input logic       exe_valid1,
  input logic       flush_all
);

  // nothing leaves the fetch buffer during a stall
  pop_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    !exe_ready |-> pop == 2'b00)
    else $error("pop raised while exe_ready is low");

  // younger slot never issues without the older one
  younger_alone: assert property (@(posedge clk) disable iff (!rst_n)
    exe_valid1 |-> exe_valid0)
    else $error("exe_valid1 high without exe_valid0");

  flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
    flush_all |=> !exe_valid0 && !exe_valid1)
    else $error("issue registers still valid after flush_all");

endmodule

bind decode_stage decode_props props_i (
  .clk        (clk),
  .rst_n      (rst_n),
  .pop        (pop),
  .exe_ready  (exe_ready),
  .exe_valid0 (exe_valid0),
  .exe_valid1 (exe_valid1),
  .flush_all  (flush_all)
);

//--- decode_stage_tb.sv
`timescale 1ns/100ps
`include "id_defs.svh"

module decode_stage_tb
  import issue_pkg::*;
();

  logic         clk;
  logic         rst_n;
  fetch_entry_t fetch0;
  fetch_entry_t fetch1;
  logic         fetch0_valid;
  logic         fetch1_valid;
  logic [1:0]   pop;
  rf_req_t      rf_req0;
  rf_req_t      rf_req1;
  rf_data_t     rf_data0;
  rf_data_t     rf_data1;
  uop_t         exe_uop0;
  uop_t         exe_uop1;
  logic         exe_valid0;
  logic         exe_valid1;
  logic         exe_ready;
  logic         flush_all;
  logic         flush_younger;
  logic         slot1_done;

  decode_stage dut_i (.*);

  always #50 clk = ~clk;

  function automatic logic [`XLEN-1:0] reg_value(input logic [4:0] idx);
    return 32'(idx) * 32'h01010101;
  endfunction

  // register file answers in the same cycle
  always_comb
  begin
    rf_data0.rj_value  = reg_value(rf_req0.raddr1);
    rf_data0.rkd_value = reg_value(rf_req0.raddr2);
    rf_data1.rj_value  = reg_value(rf_req1.raddr1);
    rf_data1.rkd_value = reg_value(rf_req1.raddr2);
  end

  function automatic logic [31:0] enc_reg(input logic [1:0] grp, input logic [4:0] op,
                                          input logic [4:0] rk, input logic [4:0] rj,
                                          input logic [4:0] rd);
    return {6'h00, 4'h0, grp, op, rk, rj, rd};
  endfunction

  function automatic logic [31:0] enc_imm12(input logic [5:0] major, input logic [3:0] minor,
                                            input logic [11:0] si12, input logic [4:0] rj,
                                            input logic [4:0] rd);
    return {major, minor, si12, rj, rd};
  endfunction

  function automatic logic [31:0] enc_branch(input logic [5:0] major, input logic [15:0] offs,
                                             input logic [4:0] rj, input logic [4:0] rd);
    return {major, offs, rj, rd};
  endfunction

  function automatic fetch_entry_t entry(input logic [31:0] instr);
    fetch_entry_t e;
    e.pc         = 32'h1c00_0100;
    e.instr      = instr;
    e.pc_is_jump = 1'b0;
    return e;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic wait_issue();
    int cycles;
    cycles = 0;
    while (!exe_valid0)
    begin
      if (cycles == 20)
      begin
        $display("timeout: exe_valid0 did not rise within 20 cycles");
        $display("FAIL: see errors above");
        $fatal(1, "issue timeout");
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  // present one bundle for a single cycle, then wait for the issue registers
  task automatic send(input fetch_entry_t e0, input fetch_entry_t e1, input logic v1,
                      input logic [1:0] exp_pop);
    @(posedge clk);
    fetch0       <= e0;
    fetch1       <= e1;
    fetch0_valid <= 1'b1;
    fetch1_valid <= v1;
    @(negedge clk);
    check("pop", 32'(pop), 32'(exp_pop));
    @(posedge clk);
    fetch0_valid <= 1'b0;
    fetch1_valid <= 1'b0;
    @(negedge clk);
    wait_issue();
    check("exe_valid1", 32'(exe_valid1), 32'(exp_pop[1]));
  endtask

  // load a pair, then freeze execute so both slots stay valid
  task automatic hold_pair(input fetch_entry_t e0, input fetch_entry_t e1);
    @(posedge clk);
    fetch0       <= e0;
    fetch1       <= e1;
    fetch0_valid <= 1'b1;
    fetch1_valid <= 1'b1;
    @(posedge clk);
    exe_ready    <= 1'b0;
    fetch0_valid <= 1'b0;
    fetch1_valid <= 1'b0;
    @(negedge clk);
    check("exe_valid0", 32'(exe_valid0), 32'h1);
    check("exe_valid1", 32'(exe_valid1), 32'h1);
  endtask

  task automatic apply_flush(input logic all, input logic younger, input logic done,
                             input logic exp0, input logic exp1);
    @(posedge clk);
    flush_all     <= all;
    flush_younger <= younger;
    slot1_done    <= done;
    @(posedge clk);
    flush_all     <= 1'b0;
    flush_younger <= 1'b0;
    slot1_done    <= 1'b0;
    exe_ready     <= 1'b1;
    @(negedge clk);
    check("exe_valid0", 32'(exe_valid0), 32'(exp0));
    check("exe_valid1", 32'(exe_valid1), 32'(exp1));
  endtask

  task automatic test_decode_fields();
    // addi r3, r2, -5
    send(entry(enc_imm12(6'h00, 4'ha, 12'hffb, 5'd2, 5'd3)), '0, 1'b0, 2'b01);
    check("alu_op", 32'(exe_uop0.alu_op.vec), 32'h001);
    check("src2_is_imm", 32'(exe_uop0.src2_is_imm), 32'h1);
    check("imm", exe_uop0.imm, 32'hffff_fffb);
    check("dest", 32'(exe_uop0.dest), 32'd3);
    check("gr_we", 32'(exe_uop0.gr_we), 32'h1);
    check("rj_value", exe_uop0.rj_value, 32'h0202_0202);
    // st.w r5, r6, 8
    send(entry(enc_imm12(6'h0a, 4'h6, 12'h008, 5'd6, 5'd5)), '0, 1'b0, 2'b01);
    check("mem_we", 32'(exe_uop0.mem_we), 32'h1);
    check("mem_mask", 32'(exe_uop0.mem_mask), 32'hf);
    check("gr_we", 32'(exe_uop0.gr_we), 32'h0);
    check("rkd_value", exe_uop0.rkd_value, 32'h0505_0505);
    // bne r7, r8
    send(entry(enc_branch(6'h17, 16'h0004, 5'd7, 5'd8)), '0, 1'b0, 2'b01);
    check("use_zero", 32'(exe_uop0.branch.use_zero), 32'h1);
    check("need_zero", 32'(exe_uop0.branch.need_zero), 32'h0);
    check("alu_op", 32'(exe_uop0.alu_op.vec), 32'h002);
  endtask

  task automatic test_dual_issue();
    send(entry(enc_reg(2'h1, 5'h00, 5'd2, 5'd1, 5'd4)),
         entry(enc_reg(2'h1, 5'h02, 5'd7, 5'd6, 5'd5)), 1'b1, 2'b11);
    check("rf_req0", 32'(rf_req0), {22'b0, 5'd1, 5'd2});
    check("rf_req1", 32'(rf_req1), {22'b0, 5'd6, 5'd7});
    check("dest0", 32'(exe_uop0.dest), 32'd4);
    check("dest1", 32'(exe_uop1.dest), 32'd5);
    check("alu_op0", 32'(exe_uop0.alu_op.vec), 32'h001);
    check("alu_op1", 32'(exe_uop1.alu_op.vec), 32'h002);
    check("rkd_value1", exe_uop1.rkd_value, 32'h0707_0707);
  endtask

  task automatic test_data_hazard();
    send(entry(enc_reg(2'h1, 5'h00, 5'd2, 5'd1, 5'd4)),
         entry(enc_reg(2'h1, 5'h02, 5'd7, 5'd4, 5'd5)), 1'b1, 2'b01);
    // r0 as destination carries no dependency
    send(entry(enc_reg(2'h1, 5'h00, 5'd2, 5'd1, 5'd0)),
         entry(enc_reg(2'h1, 5'h02, 5'd7, 5'd0, 5'd5)), 1'b1, 2'b11);
  endtask

  task automatic test_structural();
    send(entry(enc_imm12(6'h0a, 4'h2, 12'h000, 5'd1, 5'd4)),
         entry(enc_imm12(6'h0a, 4'h2, 12'h004, 5'd2, 5'd5)), 1'b1, 2'b01);
    send(entry(enc_reg(2'h1, 5'h18, 5'd2, 5'd1, 5'd4)),
         entry(enc_reg(2'h1, 5'h18, 5'd7, 5'd6, 5'd5)), 1'b1, 2'b01);
    send(entry(enc_reg(2'h2, 5'h00, 5'd2, 5'd1, 5'd4)),
         entry(enc_reg(2'h2, 5'h00, 5'd7, 5'd6, 5'd5)), 1'b1, 2'b01);
    // mul then bl
    send(entry(enc_reg(2'h1, 5'h18, 5'd2, 5'd1, 5'd4)),
         entry(enc_branch(6'h15, 16'h0010, 5'd0, 5'd0)), 1'b1, 2'b01);
    check("muldiv0", 32'(exe_uop0.muldiv), 32'h10);
    send(entry(enc_reg(2'h2, 5'h00, 5'd2, 5'd1, 5'd4)),
         entry(enc_reg(2'h1, 5'h00, 5'd7, 5'd6, 5'd5)), 1'b1, 2'b11);
    check("muldiv0", 32'(exe_uop0.muldiv), 32'h02);
    check("muldiv1", 32'(exe_uop1.muldiv), 32'h00);
  endtask

  task automatic test_stall();
    hold_pair(entry(enc_reg(2'h1, 5'h00, 5'd2, 5'd1, 5'd9)),
              entry(enc_reg(2'h1, 5'h00, 5'd7, 5'd6, 5'd10)));
    @(posedge clk);
    fetch0       <= entry(enc_reg(2'h1, 5'h00, 5'd2, 5'd1, 5'd12));
    fetch1       <= entry(enc_reg(2'h1, 5'h00, 5'd7, 5'd6, 5'd13));
    fetch0_valid <= 1'b1;
    fetch1_valid <= 1'b1;
    repeat (3)
    begin
      @(negedge clk);
      check("pop", 32'(pop), 32'h0);
      check("dest0", 32'(exe_uop0.dest), 32'd9);
      check("dest1", 32'(exe_uop1.dest), 32'd10);
      check("exe_valid1", 32'(exe_valid1), 32'h1);
    end
    @(posedge clk);
    fetch0_valid <= 1'b0;
    fetch1_valid <= 1'b0;
    exe_ready    <= 1'b1;
  endtask

  task automatic test_flush();
    hold_pair(entry(enc_reg(2'h1, 5'h00, 5'd2, 5'd1, 5'd4)),
              entry(enc_reg(2'h1, 5'h02, 5'd7, 5'd6, 5'd5)));
    apply_flush(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    hold_pair(entry(enc_reg(2'h1, 5'h00, 5'd2, 5'd1, 5'd4)),
              entry(enc_reg(2'h1, 5'h02, 5'd7, 5'd6, 5'd5)));
    apply_flush(1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
    hold_pair(entry(enc_reg(2'h1, 5'h00, 5'd2, 5'd1, 5'd4)),
              entry(enc_reg(2'h1, 5'h02, 5'd7, 5'd6, 5'd5)));
    apply_flush(1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
  endtask

  initial
  begin
    clk = 1'b0;
    rst_n         <= 1'b0;
    fetch0        <= '0;
    fetch1        <= '0;
    fetch0_valid  <= 1'b0;
    fetch1_valid  <= 1'b0;
    exe_ready     <= 1'b1;
    flush_all     <= 1'b0;
    flush_younger <= 1'b0;
    slot1_done    <= 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check("exe_valid0", 32'(exe_valid0), 32'h0);
    check("exe_valid1", 32'(exe_valid1), 32'h0);
    test_decode_fields();
    test_dual_issue();
    test_data_hazard();
    test_structural();
    test_stall();
    test_flush();
    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- flist.f
+incdir+.
isa_pkg.sv
issue_pkg.sv
instr_decoder.sv
pair_check.sv
issue_regs.sv
decode_stage.sv
decode_props.sv
decode_stage_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module decode_stage_tb -f flist.f -o decode_stage_sim

./obj_dir/decode_stage_sim
